// File: src.f
+incdir+src
src/gl_pkg.sv
src/graduation_list.sv
src/commit_ctrl.sv
src/credit_return.sv
src/grad_unit_top.sv
test/tb_grad_unit.sv

// File: run_sim.sh
#!/bin/sh
# Builds the graduation stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f src.f --top-module tb_grad_unit \
    -Mdir obj_dir -o sim_grad_unit
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_grad_unit)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1

// File: test/tb_grad_unit.sv
// Directed testbench for the graduation stage and top module of the simulation built from src.f
`timescale 1ns/100ps
`include "gl_consts.svh"

module tb_grad_unit
    import gl_pkg::*;
();

    localparam int TIMEOUT = 200;                // Cycles allowed for any wait
    localparam int PAD_W   = `GL_DATA_W - `GL_PREG_W;

    logic                  clk_i;
    logic                  rstn_i;
    logic                  dispatch_valid_i;
    instr_op_e             dispatch_op_i;
    logic [`GL_DATA_W-1:0] dispatch_pc_i;
    logic [`GL_PREG_W-1:0] dispatch_prd_i;
    gl_index_t             assigned_index_o;
    logic                  credit_o;
    logic                  wb_valid_i;
    gl_index_t             wb_index_i;
    logic [`GL_DATA_W-1:0] wb_result_i;
    exc_cause_e            wb_exc_i;
    logic                  br_flush_i;
    gl_index_t             br_keep_index_i;
    logic                  commit_valid_o;
    gl_index_t             commit_index_o;
    instr_op_e             commit_op_o;
    logic [`GL_DATA_W-1:0] commit_pc_o;
    logic [`GL_PREG_W-1:0] commit_prd_o;
    logic [`GL_DATA_W-1:0] commit_result_o;
    logic                  exception_o;
    exc_cause_e            exc_cause_o;

    grad_unit_top u_grad_unit_top (.*);

    int seed = 26918;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cyc = 0;                                 // Rising edges seen so far
    int returned = 0;                            // Credits seen on credit_o
    int dispatched = 0;                          // Credits spent by the sender
    int pc_count = 0;
    int exc_count = 0;
    exc_cause_e exc_last = EXC_NONE;
    gl_index_t  exp_tail = '0;                   // Index the next dispatch must get

    // Scoreboard with a program order queue and per slot expected fields
    gl_index_t             exp_index_q[$];
    instr_op_e             exp_op[`GL_ENTRIES];
    logic [`GL_DATA_W-1:0] exp_pc[`GL_ENTRIES];
    logic [`GL_DATA_W-1:0] exp_prd[`GL_ENTRIES];
    logic [`GL_DATA_W-1:0] exp_result[`GL_ENTRIES];
    int                    wb_stamp[`GL_ENTRIES];

    // Commits as seen on the port
    gl_index_t             obs_index_q[$];
    instr_op_e             obs_op_q[$];
    logic [`GL_DATA_W-1:0] obs_pc_q[$];
    logic [`GL_DATA_W-1:0] obs_prd_q[$];
    logic [`GL_DATA_W-1:0] obs_result_q[$];
    int                    obs_stamp_q[$];

    initial clk_i = 1'b0;
    always #10 clk_i = ~clk_i;                   // 20 ns period

    // Registered outputs read at the rising edge still hold last cycle's value
    always @(posedge clk_i) begin
        cyc = cyc + 1;
        if (credit_o) returned = returned + 1;   // Sender gets a credit back
        if (commit_valid_o) begin
            obs_index_q.push_back(commit_index_o);
            obs_op_q.push_back(commit_op_o);
            obs_pc_q.push_back(commit_pc_o);
            obs_prd_q.push_back({{PAD_W{1'b0}}, commit_prd_o});
            obs_result_q.push_back(commit_result_o);
            obs_stamp_q.push_back(cyc);
        end
        if (exception_o) begin
            exc_count = exc_count + 1;
            exc_last  = exc_cause_o;
        end
    end

    function automatic int credits_left();
        return `GL_ENTRIES - dispatched + returned;
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic check_index(input string name, input gl_index_t got, input gl_index_t exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_op(input string name, input instr_op_e got, input instr_op_e exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %s, expected %s", $time, name, got.name(),
                     exp.name());
        end
    endtask

    task automatic check_cause(input string name, input exc_cause_e got, input exc_cause_e exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %s, expected %s", $time, name, got.name(),
                     exp.name());
        end
    endtask

    task automatic check_data(input string name, input logic [`GL_DATA_W-1:0] got,
                              input logic [`GL_DATA_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    // One dispatch held for a single cycle when the sender has a credit
    task automatic dispatch(input instr_op_e op, input logic [`GL_DATA_W-1:0] pc,
                            input logic [`GL_PREG_W-1:0] prd);
        @(negedge clk_i);
        if (credits_left() <= 0) begin
            report_error("sender tried to dispatch with no credit left");
        end else begin
            check_index("assigned_index_o", assigned_index_o, exp_tail);
            dispatch_valid_i = 1'b1;
            dispatch_op_i    = op;
            dispatch_pc_i    = pc;
            dispatch_prd_i   = prd;
            exp_op[exp_tail]  = op;
            exp_pc[exp_tail]  = pc;
            exp_prd[exp_tail] = {{PAD_W{1'b0}}, prd};
            exp_index_q.push_back(exp_tail);
            exp_tail   = exp_tail + gl_index_t'(1);
            dispatched = dispatched + 1;
            @(negedge clk_i);
            dispatch_valid_i = 1'b0;
        end
    endtask

    task automatic dispatch_n(input int n);
        logic [`GL_DATA_W-1:0] r;
        for (int i = 0; i < n; i++) begin
            r = $random(seed);
            dispatch(instr_op_e'(3'(i % 5)), 32'h0000_1000 + pc_count * 4, r[`GL_PREG_W-1:0]);
            pc_count++;
        end
    endtask

    task automatic writeback(input gl_index_t idx, input exc_cause_e exc);
        @(negedge clk_i);
        wb_valid_i  = 1'b1;
        wb_index_i  = idx;
        wb_result_i = $random(seed);
        wb_exc_i    = exc;
        exp_result[idx] = wb_result_i;
        wb_stamp[idx]   = cyc;               // Sampled at the next edge
        @(negedge clk_i);
        wb_valid_i = 1'b0;
    endtask

    // Pops n commits and checks fields and timing
    // In exact mode no older entry holds a commit back
    task automatic expect_commits(input int n, input bit exact);
        int cnt;
        int earliest;
        int stamp;
        gl_index_t idx;
        earliest = 0;
        for (int k = 0; k < n; k++) begin
            cnt = 0;
            while (obs_index_q.size() == 0 && cnt < TIMEOUT) begin
                @(negedge clk_i);
                cnt++;
            end
            if (obs_index_q.size() == 0) begin
                report_error("timed out waiting for a commit");
                return;
            end
            if (exp_index_q.size() == 0) begin
                report_error("commit arrived with no entry left in program order");
                return;
            end
            idx = exp_index_q.pop_front();
            if (wb_stamp[idx] + 3 > earliest) earliest = wb_stamp[idx] + 3; // Two edges later
            check_index("commit_index_o", obs_index_q.pop_front(), idx);
            check_op("commit_op_o", obs_op_q.pop_front(), exp_op[idx]);
            check_data("commit_pc_o", obs_pc_q.pop_front(), exp_pc[idx]);
            check_data("commit_prd_o", obs_prd_q.pop_front(), exp_prd[idx]);
            check_data("commit_result_o", obs_result_q.pop_front(), exp_result[idx]);
            stamp = obs_stamp_q.pop_front();
            if (exact && stamp != earliest) begin
                report_error($sformatf("entry %0d committed at cycle %0d, expected %0d",
                             idx, stamp, earliest));
            end else if (!exact && stamp < earliest) begin
                report_error($sformatf("entry %0d committed at cycle %0d, before cycle %0d",
                             idx, stamp, earliest));
            end
        end
    endtask

    // Observation window in which no commit may show up
    task automatic expect_quiet(input int n);
        repeat (n) @(negedge clk_i);
        if (obs_index_q.size() != 0) begin
            report_error($sformatf("%0d unexpected commits seen", obs_index_q.size()));
            obs_index_q.delete();
            obs_op_q.delete();
            obs_pc_q.delete();
            obs_prd_q.delete();
            obs_result_q.delete();
            obs_stamp_q.delete();
        end
    endtask

    task automatic wait_returns(input int target);
        int cnt;
        cnt = 0;
        while (returned < target && cnt < TIMEOUT) begin
            @(negedge clk_i);
            cnt++;
        end
        if (returned != target)
            report_error($sformatf("%0d credits returned, expected %0d", returned, target));
    endtask

    task automatic test_in_order();
        dispatch_n(4);
        for (int i = 0; i < 4; i++) writeback(exp_index_q[i], EXC_NONE);
        expect_commits(4, 1'b1);
        wait_returns(dispatched);
    endtask

    task automatic test_out_of_order();
        gl_index_t order[`GL_ENTRIES];
        gl_index_t t;
        int j;
        dispatch_n(8);
        for (int i = 0; i < 8; i++) order[i] = exp_index_q[i];
        for (int i = 7; i > 0; i--) begin    // Shuffle the writeback order
            j = {$random(seed)} % (i + 1);
            t = order[i];
            order[i] = order[j];
            order[j] = t;
        end
        for (int i = 0; i < 8; i++) writeback(order[i], EXC_NONE);
        expect_commits(8, 1'b0);
        wait_returns(dispatched);
    endtask

    task automatic test_credits();
        int r0;
        r0 = returned;
        dispatch_n(8);                       // Tail wraps past the last slot here
        repeat (4) @(negedge clk_i);
        if (credits_left() != 0) report_error("sender holds credits while the list is full");
        for (int i = 0; i < 8; i++) writeback(exp_index_q[i], EXC_NONE);
        expect_commits(8, 1'b0);
        wait_returns(dispatched);
        if (returned - r0 != 8) report_error("commits did not return one credit each");
    endtask

    task automatic test_branch_flush();
        gl_index_t keep;
        int r0;
        dispatch_n(6);
        keep = exp_index_q[1];
        // Younger entries finish before the flush and must still never commit
        for (int i = 2; i < 6; i++) writeback(exp_index_q[i], EXC_NONE);
        r0   = returned;
        @(negedge clk_i);
        br_flush_i      = 1'b1;
        br_keep_index_i = keep;
        @(negedge clk_i);
        br_flush_i = 1'b0;
        while (exp_index_q.size() > 2) void'(exp_index_q.pop_back());
        exp_tail = keep + gl_index_t'(1);
        check_index("assigned_index_o", assigned_index_o, exp_tail);
        wait_returns(r0 + 4);                // Squashed entries only
        repeat (3) @(negedge clk_i);
        if (returned - r0 != 4) report_error("branch flush returned the wrong credit count");
        for (int i = 0; i < 2; i++) writeback(exp_index_q[i], EXC_NONE);
        expect_commits(2, 1'b0);
        expect_quiet(4);
        wait_returns(dispatched);
    endtask

    task automatic test_exception();
        gl_index_t old_head;
        int e0;
        int cnt;
        dispatch_n(3);
        old_head = exp_index_q[0];
        e0 = exc_count;
        writeback(exp_index_q[1], EXC_NONE); // Younger entry finishes first
        writeback(old_head, EXC_LOAD_FAULT);
        cnt = 0;
        while (exc_count == e0 && cnt < TIMEOUT) begin
            @(negedge clk_i);
            cnt++;
        end
        if (exc_count == e0) report_error("no exception reported for the faulting head");
        else check_cause("exc_cause_o", exc_last, EXC_LOAD_FAULT);
        exp_index_q.delete();
        exp_tail = old_head + gl_index_t'(1);
        wait_returns(dispatched);
        expect_quiet(2);
        if (exc_count != e0 + 1) report_error("exception_o was not a single cycle pulse");
        dispatch_n(1);
        writeback(exp_index_q[0], EXC_NONE);
        expect_commits(1, 1'b1);
        wait_returns(dispatched);
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("Test %s finished without errors", name);
        end else begin
            tests_failed++;
            $display("Test %s finished with %0d errors", name, errors - err_before);
        end
    endtask

    initial begin
        int e0;
        rstn_i           = 1'b0;
        dispatch_valid_i = 1'b0;
        dispatch_op_i    = OP_ALU;
        dispatch_pc_i    = '0;
        dispatch_prd_i   = '0;
        wb_valid_i       = 1'b0;
        wb_index_i       = '0;
        wb_result_i      = '0;
        wb_exc_i         = EXC_NONE;
        br_flush_i       = 1'b0;
        br_keep_index_i  = '0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;
        if (commit_valid_o || exception_o || credit_o)
            report_error("outputs not idle after reset");
        e0 = errors;
        test_in_order();
        finish_test("in-order retire", e0);
        e0 = errors;
        test_out_of_order();
        finish_test("out-of-order writeback", e0);
        e0 = errors;
        test_credits();
        finish_test("credits", e0);
        e0 = errors;
        test_branch_flush();
        finish_test("branch flush", e0);
        e0 = errors;
        test_exception();
        finish_test("exception", e0);
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: src/grad_unit_top.sv
// Graduation stage top level tying the list, the commit FSM and the credit counter together
`timescale 1ns/100ps
`include "gl_consts.svh"

module grad_unit_top
    import gl_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rstn_i,
    // Dispatch
    input  logic                  dispatch_valid_i,
    input  instr_op_e             dispatch_op_i,
    input  logic [`GL_DATA_W-1:0] dispatch_pc_i,
    input  logic [`GL_PREG_W-1:0] dispatch_prd_i,
    output gl_index_t             assigned_index_o,
    output logic                  credit_o,
    // Writeback
    input  logic                  wb_valid_i,
    input  gl_index_t             wb_index_i,
    input  logic [`GL_DATA_W-1:0] wb_result_i,
    input  exc_cause_e            wb_exc_i,
    // Branch flush
    input  logic                  br_flush_i,
    input  gl_index_t             br_keep_index_i,
    // Commit
    output logic                  commit_valid_o,
    output gl_index_t             commit_index_o,
    output instr_op_e             commit_op_o,
    output logic [`GL_DATA_W-1:0] commit_pc_o,
    output logic [`GL_PREG_W-1:0] commit_prd_o,
    output logic [`GL_DATA_W-1:0] commit_result_o,
    output logic                  exception_o,
    output exc_cause_e            exc_cause_o
);

    logic       head_done;
    exc_cause_e head_exc;
    logic       retire;
    logic       flush_all;
    logic       flush_keep;
    gl_index_t  keep_index;
    logic       free_pulse;
    gl_count_t  squash_count;
    gl_count_t  credits_pending;

    // In-order storage
    graduation_list u_graduation_list (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_op_i    (dispatch_op_i),
        .dispatch_pc_i    (dispatch_pc_i),
        .dispatch_prd_i   (dispatch_prd_i),
        .wb_valid_i       (wb_valid_i),
        .wb_index_i       (wb_index_i),
        .wb_result_i      (wb_result_i),
        .wb_exc_i         (wb_exc_i),
        .retire_i         (retire),
        .flush_all_i      (flush_all),
        .flush_keep_i     (flush_keep),
        .keep_index_i     (keep_index),
        .head_done_o      (head_done),
        .head_exc_o       (head_exc),
        .assigned_index_o (assigned_index_o),
        .commit_valid_o   (commit_valid_o),
        .commit_index_o   (commit_index_o),
        .commit_op_o      (commit_op_o),
        .commit_pc_o      (commit_pc_o),
        .commit_prd_o     (commit_prd_o),
        .commit_result_o  (commit_result_o),
        .free_pulse_o     (free_pulse),
        .squash_count_o   (squash_count)
    );

    // Retire and flush decisions
    commit_ctrl u_commit_ctrl (
        .clk_i             (clk_i),
        .rstn_i            (rstn_i),
        .head_done_i       (head_done),
        .head_exc_i        (head_exc),
        .br_flush_i        (br_flush_i),
        .br_keep_index_i   (br_keep_index_i),
        .credits_pending_i (credits_pending),
        .retire_o          (retire),
        .flush_all_o       (flush_all),
        .flush_keep_o      (flush_keep),
        .keep_index_o      (keep_index),
        .exception_o       (exception_o),
        .exc_cause_o       (exc_cause_o)
    );

    // Dispatch credit return
    credit_return u_credit_return (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .free_pulse_i   (free_pulse),
        .squash_count_i (squash_count),
        .credit_o       (credit_o),
        .pending_o      (credits_pending)
    );

endmodule

// File: src/credit_return.sv
// Pending credit counter that returns freed list entries to the dispatch sender, one per cycle
`timescale 1ns/100ps

module credit_return
    import gl_pkg::*;
(
    input  logic      clk_i,
    input  logic      rstn_i,
    input  logic      free_pulse_i,     // One entry retired this cycle
    input  gl_count_t squash_count_i,   // Entries removed by a flush
    output logic      credit_o,         // One credit back to the sender
    output gl_count_t pending_o         // Freed entries not yet returned
);

    gl_count_t pending_q;
    logic      give;

    // Return one credit whenever anything is pending
    assign give = (pending_q != '0);

    // Never exceeds the list depth, since pending plus occupied plus sender credits is constant
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pending_q <= '0;
        end else begin
            pending_q <= pending_q + gl_count_t'(free_pulse_i) + squash_count_i
                         - gl_count_t'(give);
        end
    end

    // Registered credit strobe
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            credit_o <= 1'b0;
        end else begin
            credit_o <= give;
        end
    end

    assign pending_o = pending_q;

endmodule

// File: src/commit_ctrl.sv
// Commit FSM deciding head retire, exception flush and branch flush forwarding
`timescale 1ns/100ps

module commit_ctrl
    import gl_pkg::*;
(
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       head_done_i,       // Head present and finished
    input  exc_cause_e head_exc_i,        // Cause stored for the head
    input  logic       br_flush_i,        // Branch mispredict from execute
    input  gl_index_t  br_keep_index_i,
    input  gl_count_t  credits_pending_i, // Credits not yet returned
    output logic       retire_o,
    output logic       flush_all_o,
    output logic       flush_keep_o,
    output gl_index_t  keep_index_o,
    output logic       exception_o,
    output exc_cause_e exc_cause_o
);

    commit_state_e state_q;
    commit_state_e state_d;
    exc_cause_e    cause_q;        // Cause latched at the flush edge
    logic          head_exc;

    assign head_exc = head_done_i & (head_exc_i != EXC_NONE);

    // Next state and control outputs
    always_comb begin
        state_d      = state_q;
        retire_o     = 1'b0;
        flush_all_o  = 1'b0;
        flush_keep_o = 1'b0;
        case (state_q)
            CS_RUN: begin
                retire_o = head_done_i;         // Pops the head in either case
                if (head_exc) begin
                    flush_all_o = 1'b1;         // Empties the list
                    state_d     = CS_EXCEPT;
                end else begin
                    flush_keep_o = br_flush_i;  // Exception flush takes priority
                end
            end
            CS_EXCEPT: begin
                state_d = CS_DRAIN;             // Report lasts one cycle
            end
            CS_DRAIN: begin
                // Stay until every freed entry has gone back as a credit
                if (credits_pending_i == '0) begin
                    state_d = CS_RUN;
                end
            end
            default: begin
                state_d = CS_RUN;
            end
        endcase
    end

    assign keep_index_o = br_keep_index_i;

    // State register
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= CS_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    // Cause capture when the exception flush fires
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cause_q <= EXC_NONE;
        end else if (flush_all_o) begin
            cause_q <= head_exc_i;
        end
    end

    // Exception report is high only in CS_EXCEPT
    assign exception_o = (state_q == CS_EXCEPT);
    assign exc_cause_o = exception_o ? cause_q : EXC_NONE;

endmodule

// File: src/graduation_list.sv
// Circular in-order list of in-flight instructions that is written at dispatch and popped at commit
`timescale 1ns/100ps
`include "gl_consts.svh"

module graduation_list
    import gl_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rstn_i,
    // Dispatch from the renamer
    input  logic                  dispatch_valid_i,
    input  instr_op_e             dispatch_op_i,
    input  logic [`GL_DATA_W-1:0] dispatch_pc_i,
    input  logic [`GL_PREG_W-1:0] dispatch_prd_i,
    // Writeback in any order
    input  logic                  wb_valid_i,
    input  gl_index_t             wb_index_i,
    input  logic [`GL_DATA_W-1:0] wb_result_i,
    input  exc_cause_e            wb_exc_i,
    // Control from the commit FSM
    input  logic                  retire_i,
    input  logic                  flush_all_i,
    input  logic                  flush_keep_i,
    input  gl_index_t             keep_index_i,   // Last correct entry on a branch flush
    // Head status
    output logic                  head_done_o,
    output exc_cause_e            head_exc_o,
    output gl_index_t             assigned_index_o,
    // Registered commit port
    output logic                  commit_valid_o,
    output gl_index_t             commit_index_o,
    output instr_op_e             commit_op_o,
    output logic [`GL_DATA_W-1:0] commit_pc_o,
    output logic [`GL_PREG_W-1:0] commit_prd_o,
    output logic [`GL_DATA_W-1:0] commit_result_o,
    // Credit accounting
    output logic                  free_pulse_o,
    output gl_count_t             squash_count_o
);

    localparam int unsigned NUM_ENTRIES = `GL_ENTRIES;

    // Entry payload
    instr_op_e             op_q     [NUM_ENTRIES];
    logic [`GL_DATA_W-1:0] pc_q     [NUM_ENTRIES];
    logic [`GL_PREG_W-1:0] prd_q    [NUM_ENTRIES];
    logic [`GL_DATA_W-1:0] result_q [NUM_ENTRIES];
    exc_cause_e            exc_q    [NUM_ENTRIES];
    logic [NUM_ENTRIES-1:0] done_q;               // Finished bits

    gl_index_t head_q;                            // Oldest entry
    gl_index_t tail_q;                            // Next free slot
    gl_count_t num_q;                             // Occupancy

    logic      full;
    logic      flush_any;
    logic      write_en;
    logic      drop_en;
    gl_index_t head_next;
    gl_count_t kept_cnt;

    assign full      = (num_q == gl_count_t'(NUM_ENTRIES));
    assign flush_any = flush_all_i | flush_keep_i;
    assign write_en  = dispatch_valid_i & ~flush_any & ~full;
    assign drop_en   = dispatch_valid_i & flush_any;   // Dispatch lost to a flush
    assign head_next = head_q + gl_index_t'(retire_i);

    // Entries from the head up to and including the keep index with wraparound
    assign kept_cnt = gl_count_t'(gl_index_t'(keep_index_i - head_q)) + gl_count_t'(1);

    // Entries removed by a flush
    // A head retired in the same cycle goes out through free_pulse_o
    always_comb begin
        squash_count_o = '0;
        if (flush_all_i) begin
            squash_count_o = num_q - gl_count_t'(retire_i) + gl_count_t'(drop_en);
        end else if (flush_keep_i) begin
            squash_count_o = num_q - kept_cnt + gl_count_t'(drop_en);
        end
    end

    assign free_pulse_o     = retire_i;
    assign head_done_o      = (num_q != '0) & done_q[head_q];
    assign head_exc_o       = exc_q[head_q];
    assign assigned_index_o = tail_q;

    // Payload writes at dispatch and at writeback
    always_ff @(posedge clk_i) begin
        if (write_en) begin
            op_q[tail_q]  <= dispatch_op_i;
            pc_q[tail_q]  <= dispatch_pc_i;
            prd_q[tail_q] <= dispatch_prd_i;
        end
        if (wb_valid_i) begin
            result_q[wb_index_i] <= wb_result_i;
            exc_q[wb_index_i]    <= wb_exc_i;
        end
    end

    // Finished bits are cleared when a slot is reused
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            done_q <= '0;
        end else begin
            if (write_en) done_q[tail_q] <= 1'b0;
            if (wb_valid_i) done_q[wb_index_i] <= 1'b1;    // Index assumed occupied
        end
    end

    // Pointer and occupancy update
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q <= '0;
            tail_q <= '0;
            num_q  <= '0;
        end else if (flush_all_i) begin
            head_q <= head_next;              // Next dispatch follows the old head
            tail_q <= head_next;
            num_q  <= '0;
        end else if (flush_keep_i) begin
            head_q <= head_next;
            tail_q <= keep_index_i + gl_index_t'(1);
            num_q  <= kept_cnt - gl_count_t'(retire_i); // Head may retire this cycle
        end else begin
            head_q <= head_next;
            tail_q <= tail_q + gl_index_t'(write_en);
            num_q  <= num_q + gl_count_t'(write_en) - gl_count_t'(retire_i);
        end
    end

    // Commit valid is suppressed for an excepting head
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            commit_valid_o <= 1'b0;
        end else begin
            commit_valid_o <= retire_i & ~flush_all_i;
        end
    end

    // Commit fields hold between retires
    always_ff @(posedge clk_i) begin
        if (retire_i && !flush_all_i) begin
            commit_index_o  <= head_q;
            commit_op_o     <= op_q[head_q];
            commit_pc_o     <= pc_q[head_q];
            commit_prd_o    <= prd_q[head_q];
            commit_result_o <= result_q[head_q];
        end
    end

endmodule

// File: src/gl_pkg.sv
// Shared types for the graduation stage, imported by every module of the subsystem

package gl_pkg;

`include "gl_consts.svh"

    // Entry index, wraps naturally since the depth is a power of two
    typedef logic [$clog2(`GL_ENTRIES)-1:0] gl_index_t;

    // Entry count, one bit wider so a full list is representable
    typedef logic [$clog2(`GL_ENTRIES):0] gl_count_t;

    // Instruction class carried from dispatch to commit
    typedef enum logic [2:0] {
        OP_ALU    = 3'd0,
        OP_LOAD   = 3'd1,
        OP_STORE  = 3'd2,
        OP_BRANCH = 3'd3, // Resolved in execute, may flush younger entries
        OP_CSR    = 3'd4
    } instr_op_e;

    // Exception cause reported at writeback
    typedef enum logic [1:0] {
        EXC_NONE        = 2'd0, // Normal completion
        EXC_ILLEGAL     = 2'd1,
        EXC_LOAD_FAULT  = 2'd2,
        EXC_STORE_FAULT = 2'd3
    } exc_cause_e;

    // Commit controller states
    typedef enum logic [1:0] {
        CS_RUN    = 2'd0, // Retire finished heads
        CS_EXCEPT = 2'd1, // Report the exception for one cycle
        CS_DRAIN  = 2'd2  // Wait for all freed credits to go back
    } commit_state_e;

endpackage

// File: src/gl_consts.svh
// Sizing constants for the graduation list, included by the package and by RTL that needs widths
`ifndef GL_CONSTS_SVH
`define GL_CONSTS_SVH

// Number of in-flight instructions the list can hold
`define GL_ENTRIES 8

// Width of a result value and of a program counter
`define GL_DATA_W 32

// Width of a physical register tag from the renamer
`define GL_PREG_W 6

`endif
